// ==== rtl/mul_params.svh ====
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// operand width
`define MUL_XLEN 64

// product width, also the width of every partial-product row
`define MUL_PLEN (2 * `MUL_XLEN)

// radix-4 digits over the operand plus two extension bits
`define MUL_PP_ROWS ((`MUL_XLEN + 2) / 2)

// steps from the booth state up to result capture
`define MUL_STEPS 5

`endif

// ==== rtl/mul_pkg.sv ====
package mul_pkg;

`include "mul_params.svh"

  // one source operand
  typedef logic [`MUL_XLEN-1:0] operand_t;

  // partial-product row, also the product
  typedef logic [`MUL_PLEN-1:0] row_t;

  // controller states
  typedef enum logic [1:0] {
    MUL_RST,
    MUL_IDLE,
    MUL_RUN
  } mul_state_t;

endpackage

// ==== rtl/booth_r4_encoder.sv ====
`timescale 1ns/1ps

`include "mul_params.svh"

module booth_r4_encoder (
  input  logic              rs1_signed_i,
  input  logic              rs2_signed_i,
  input  mul_pkg::operand_t rs1_data_i,
  input  mul_pkg::operand_t rs2_data_i,
  output mul_pkg::row_t     pp_o [`MUL_PP_ROWS]
);
  import mul_pkg::*;

  // operands widened by two bits, sign or zero fill by flag
  logic [`MUL_XLEN+1:0] a_ext;
  logic [`MUL_XLEN+1:0] b_ext;
  // multiplier with the implicit zero below bit 0
  logic [`MUL_XLEN+2:0] b_pad;

  // multiplicand and its double, sign-extended to full width
  row_t mcand;
  row_t mcand2;

  assign a_ext = {{2{rs1_signed_i & rs1_data_i[`MUL_XLEN-1]}}, rs1_data_i};
  assign b_ext = {{2{rs2_signed_i & rs2_data_i[`MUL_XLEN-1]}}, rs2_data_i};
  assign b_pad = {b_ext, 1'b0};

  assign mcand  = {{(`MUL_PLEN - `MUL_XLEN - 2){a_ext[`MUL_XLEN+1]}}, a_ext};
  assign mcand2 = mcand << 1;

  // one digit per overlapping three-bit group
  always_comb begin
    logic [2:0] grp;
    logic       neg;
    row_t       sel;
    for (int i = 0; i < `MUL_PP_ROWS; i++) begin
      grp = b_pad[2*i +: 3];
      // digits -1 and -2, group 111 is zero
      neg = grp[2] & ~(grp[1] & grp[0]);
      case (grp)
        3'b001, 3'b010, 3'b101, 3'b110: begin
          sel = mcand;
        end
        3'b011, 3'b100: begin
          sel = mcand2;
        end
        default: begin
          sel = '0;
        end
      endcase
      // invert plus one folded in here, then weight by 4^i
      pp_o[i] = ((sel ^ {`MUL_PLEN{neg}}) + row_t'(neg)) << (2 * i);
    end
  end

endmodule

// ==== rtl/csa42_row.sv ====
`timescale 1ns/1ps

`include "mul_params.svh"

module csa42_row (
  input  mul_pkg::row_t x0_i,
  input  mul_pkg::row_t x1_i,
  input  mul_pkg::row_t x2_i,
  input  mul_pkg::row_t x3_i,
  output mul_pkg::row_t sum_o,
  output mul_pkg::row_t carry_o
);
  import mul_pkg::*;

  // lateral carry into each bit
  row_t lat;

  assign lat[0] = 1'b0;

  for (genvar i = 0; i < `MUL_PLEN; i++) begin : g_bit
    logic s1;

    // first three inputs reduced to one
    assign s1 = x0_i[i] ^ x1_i[i] ^ x2_i[i];

    assign sum_o[i]   = s1 ^ x3_i[i] ^ lat[i];
    assign carry_o[i] = (s1 & x3_i[i]) | (s1 & lat[i]) | (x3_i[i] & lat[i]);

    // lateral out depends on inputs only, so no ripple
    if (i < `MUL_PLEN - 1) begin : g_lat
      assign lat[i+1] = (x0_i[i] & x1_i[i]) | (x0_i[i] & x2_i[i]) | (x1_i[i] & x2_i[i]);
    end
  end

endmodule

// ==== rtl/csa52_row.sv ====
`timescale 1ns/1ps

`include "mul_params.svh"

module csa52_row (
  input  mul_pkg::row_t x0_i,
  input  mul_pkg::row_t x1_i,
  input  mul_pkg::row_t x2_i,
  input  mul_pkg::row_t x3_i,
  input  mul_pkg::row_t x4_i,
  output mul_pkg::row_t sum_o,
  output mul_pkg::row_t carry_o
);
  import mul_pkg::*;

  // two lateral chains, both zero at bit 0
  row_t lat0;
  row_t lat1;

  assign lat0[0] = 1'b0;
  assign lat1[0] = 1'b0;

  for (genvar i = 0; i < `MUL_PLEN; i++) begin : g_bit
    logic sa;
    logic sb;

    // first full adder on x0..x2
    assign sa = x0_i[i] ^ x1_i[i] ^ x2_i[i];
    // second stage takes x3 and chain 0
    assign sb = sa ^ x3_i[i] ^ lat0[i];

    // last stage takes x4 and chain 1
    assign sum_o[i]   = sb ^ x4_i[i] ^ lat1[i];
    assign carry_o[i] = (sb & x4_i[i]) | (sb & lat1[i]) | (x4_i[i] & lat1[i]);

    if (i < `MUL_PLEN - 1) begin : g_lat
      assign lat0[i+1] = (x0_i[i] & x1_i[i]) | (x0_i[i] & x2_i[i]) | (x1_i[i] & x2_i[i]);
      assign lat1[i+1] = (sa & x3_i[i]) | (sa & lat0[i]) | (x3_i[i] & lat0[i]);
    end
  end

endmodule

// ==== rtl/wallace_level.sv ====
`timescale 1ns/1ps

module wallace_level #(
  parameter int ROWS_IN = 4
) (
  input  logic          clk,
  input  logic          rst,
  input  mul_pkg::row_t rows_i [ROWS_IN],
  output mul_pkg::row_t rows_o [ROWS_IN/2]
);
  import mul_pkg::*;

  // a remainder of one puts a 5-2 group first
  localparam bit HAS5   = (ROWS_IN % 4) == 1;
  localparam int OFF    = HAS5 ? 1 : 0;
  localparam int GROUPS = ROWS_IN / 4;

  row_t rows_q    [ROWS_IN];
  row_t grp_sum   [GROUPS];
  row_t grp_carry [GROUPS];

  // input register, loads every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rows_q <= '{default: '0};
    end else begin
      rows_q <= rows_i;
    end
  end

  for (genvar g = 0; g < GROUPS; g++) begin : g_grp
    localparam int BASE = (g == 0) ? 0 : 4 * g + OFF;

    if (HAS5 && g == 0) begin : g_c52
      csa52_row u_csa52 (
        .x0_i    (rows_q[0]),
        .x1_i    (rows_q[1]),
        .x2_i    (rows_q[2]),
        .x3_i    (rows_q[3]),
        .x4_i    (rows_q[4]),
        .sum_o   (grp_sum[g]),
        .carry_o (grp_carry[g])
      );
    end else begin : g_c42
      csa42_row u_csa42 (
        .x0_i    (rows_q[BASE]),
        .x1_i    (rows_q[BASE+1]),
        .x2_i    (rows_q[BASE+2]),
        .x3_i    (rows_q[BASE+3]),
        .sum_o   (grp_sum[g]),
        .carry_o (grp_carry[g])
      );
    end

    // sums first, then carries at weight two
    assign rows_o[g]        = grp_sum[g];
    assign rows_o[GROUPS+g] = grp_carry[g] << 1;
  end

endmodule

// ==== rtl/wallace_tree.sv ====
`timescale 1ns/1ps

`include "mul_params.svh"

module wallace_tree (
  input  logic          clk,
  input  logic          rst,
  input  mul_pkg::row_t pp_i [`MUL_PP_ROWS],
  output mul_pkg::row_t sum_o
);
  import mul_pkg::*;

  row_t l1_rows  [`MUL_PP_ROWS/2];
  row_t l2_rows  [`MUL_PP_ROWS/4];
  row_t l3_rows  [`MUL_PP_ROWS/8];
  row_t l4_rows  [2];
  row_t fin_q    [2];

  // 33 -> 16, one 5-2 group and seven 4-2 groups
  wallace_level #(.ROWS_IN(`MUL_PP_ROWS)) u_level1 (
    .clk    (clk),
    .rst    (rst),
    .rows_i (pp_i),
    .rows_o (l1_rows)
  );

  wallace_level #(.ROWS_IN(`MUL_PP_ROWS/2)) u_level2 (
    .clk    (clk),
    .rst    (rst),
    .rows_i (l1_rows),
    .rows_o (l2_rows)
  );

  wallace_level #(.ROWS_IN(`MUL_PP_ROWS/4)) u_level3 (
    .clk    (clk),
    .rst    (rst),
    .rows_i (l2_rows),
    .rows_o (l3_rows)
  );

  // 4 -> 2
  wallace_level #(.ROWS_IN(`MUL_PP_ROWS/8)) u_level4 (
    .clk    (clk),
    .rst    (rst),
    .rows_i (l3_rows),
    .rows_o (l4_rows)
  );

  // last two rows held for the final add
  always_ff @(posedge clk) begin
    if (rst) begin
      fin_q <= '{default: '0};
    end else begin
      fin_q <= l4_rows;
    end
  end

  assign sum_o = fin_q[0] + fin_q[1];

endmodule

// ==== rtl/mul_ctrl.sv ====
`timescale 1ns/1ps

`include "mul_params.svh"

module mul_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              mul_valid_i,
  input  logic              rs1_signed_i,
  input  logic              rs2_signed_i,
  input  mul_pkg::operand_t rs1_data_i,
  input  mul_pkg::operand_t rs2_data_i,
  input  mul_pkg::row_t     final_sum_i,
  output mul_pkg::operand_t booth_rs1_o,
  output mul_pkg::operand_t booth_rs2_o,
  output logic              booth_rs1_signed_o,
  output logic              booth_rs2_signed_o,
  output logic              mul_ready_o,
  output mul_pkg::row_t     mul_out_o
);
  import mul_pkg::*;

  localparam int CNT_W = $clog2(`MUL_STEPS + 1);

  mul_state_t       state;
  logic [CNT_W-1:0] step_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= MUL_RST;
      step_cnt    <= '0;
      mul_ready_o <= 1'b0;
      mul_out_o   <= '0;
    end else begin
      case (state)
        MUL_RST: begin
          state <= MUL_IDLE;
        end
        MUL_IDLE: begin
          mul_ready_o <= 1'b0;
          if (mul_valid_i) begin
            state    <= MUL_RUN;
            step_cnt <= '0;
          end
        end
        MUL_RUN: begin
          if (!mul_valid_i) begin
            // requester gave up, drop the result
            state     <= MUL_IDLE;
            step_cnt  <= '0;
            mul_out_o <= '0;
          end else if (step_cnt == CNT_W'(`MUL_STEPS)) begin
            state       <= MUL_IDLE;
            mul_out_o   <= final_sum_i;
            mul_ready_o <= 1'b1;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        default: begin
          state <= MUL_IDLE;
        end
      endcase
    end
  end

  // operands captured on the accept edge
  always_ff @(posedge clk) begin
    if (state == MUL_IDLE && mul_valid_i) begin
      booth_rs1_o        <= rs1_data_i;
      booth_rs2_o        <= rs2_data_i;
      booth_rs1_signed_o <= rs1_signed_i;
      booth_rs2_signed_o <= rs2_signed_i;
    end
  end

endmodule

// ==== rtl/wallace_mul.sv ====
`timescale 1ns/1ps

`include "mul_params.svh"

module wallace_mul (
  input  logic              clk,
  input  logic              rst,
  input  logic              mul_valid_i,
  input  logic              rs1_signed_i,
  input  logic              rs2_signed_i,
  input  mul_pkg::operand_t rs1_data_i,
  input  mul_pkg::operand_t rs2_data_i,
  output logic              mul_ready_o,
  output mul_pkg::row_t     mul_out_o
);
  import mul_pkg::*;

  operand_t booth_rs1;
  operand_t booth_rs2;
  logic     booth_rs1_signed;
  logic     booth_rs2_signed;
  row_t     pp [`MUL_PP_ROWS];
  row_t     final_sum;

  mul_ctrl u_ctrl (
    .clk                (clk),
    .rst                (rst),
    .mul_valid_i        (mul_valid_i),
    .rs1_signed_i       (rs1_signed_i),
    .rs2_signed_i       (rs2_signed_i),
    .rs1_data_i         (rs1_data_i),
    .rs2_data_i         (rs2_data_i),
    .final_sum_i        (final_sum),
    .booth_rs1_o        (booth_rs1),
    .booth_rs2_o        (booth_rs2),
    .booth_rs1_signed_o (booth_rs1_signed),
    .booth_rs2_signed_o (booth_rs2_signed),
    .mul_ready_o        (mul_ready_o),
    .mul_out_o          (mul_out_o)
  );

  booth_r4_encoder u_booth (
    .rs1_signed_i (booth_rs1_signed),
    .rs2_signed_i (booth_rs2_signed),
    .rs1_data_i   (booth_rs1),
    .rs2_data_i   (booth_rs2),
    .pp_o         (pp)
  );

  wallace_tree u_tree (
    .clk   (clk),
    .rst   (rst),
    .pp_i  (pp),
    .sum_o (final_sum)
  );

endmodule

// ==== verification/wallace_mul_tb.sv ====
`timescale 1ns/1ps

`include "mul_params.svh"

module wallace_mul_tb;
  import mul_pkg::*;

  localparam int READY_WAIT = 20;
  // edges from acceptance to the ready pulse
  localparam int EXP_LAT = `MUL_STEPS + 1;

  logic     clk;
  logic     rst;
  logic     mul_valid;
  logic     rs1_signed;
  logic     rs2_signed;
  operand_t rs1_data;
  operand_t rs2_data;
  logic     mul_ready;
  row_t     mul_out;

  // stimulus table with expected products
  string    name_q  [$];
  operand_t rs1_q   [$];
  operand_t rs2_q   [$];
  bit       s1_q    [$];
  bit       s2_q    [$];
  int       abort_q [$];
  row_t     exp_q   [$];

  int seed;
  int cycle_cnt;
  int cycle_limit;
  int pass_cnt;
  int fail_cnt;
  int test_errs;

  wallace_mul DUT (
    .clk          (clk),
    .rst          (rst),
    .mul_valid_i  (mul_valid),
    .rs1_signed_i (rs1_signed),
    .rs2_signed_i (rs2_signed),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .mul_ready_o  (mul_ready),
    .mul_out_o    (mul_out)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  // each operand extended by its own flag, product kept to 128 bits
  function automatic row_t expected_product(input operand_t a, input operand_t b,
                                            input bit sa, input bit sb);
    row_t ea;
    row_t eb;
    ea = sa ? {{`MUL_XLEN{a[`MUL_XLEN-1]}}, a} : {{`MUL_XLEN{1'b0}}, a};
    eb = sb ? {{`MUL_XLEN{b[`MUL_XLEN-1]}}, b} : {{`MUL_XLEN{1'b0}}, b};
    return ea * eb;
  endfunction

  task automatic add_entry(input string name, input operand_t a, input operand_t b,
                           input bit sa, input bit sb, input int abort);
    name_q.push_back(name);
    rs1_q.push_back(a);
    rs2_q.push_back(b);
    s1_q.push_back(sa);
    s2_q.push_back(sb);
    abort_q.push_back(abort);
    exp_q.push_back(expected_product(a, b, sa, sb));
  endtask

  task automatic build_table();
    operand_t    a;
    operand_t    b;
    logic [31:0] r;
    // unsigned
    add_entry("zero", 64'd0, 64'h1234_5678_9abc_def0, 1'b0, 1'b0, 0);
    add_entry("one_one", 64'd1, 64'd1, 1'b0, 1'b0, 0);
    add_entry("ones_ones", '1, '1, 1'b0, 1'b0, 0);
    add_entry("pow63_pow63", 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b0, 1'b0, 0);
    add_entry("pow32_pow31", 64'h1_0000_0000, 64'h8000_0000, 1'b0, 1'b0, 0);
    add_entry("one_ones", 64'd1, '1, 1'b0, 1'b0, 0);
    // signed and mixed sign
    add_entry("neg1_neg1", '1, '1, 1'b1, 1'b1, 0);
    add_entry("neg5_pos7", 64'hFFFF_FFFF_FFFF_FFFB, 64'd7, 1'b1, 1'b1, 0);
    add_entry("min_neg1", 64'h8000_0000_0000_0000, '1, 1'b1, 1'b1, 0);
    add_entry("smin_uones", 64'h8000_0000_0000_0000, '1, 1'b1, 1'b0, 0);
    add_entry("uones_sneg3", '1, 64'hFFFF_FFFF_FFFF_FFFD, 1'b0, 1'b1, 0);
    // 1000 pattern in the multiplier gives digit -2 groups
    add_entry("cccc_8888", 64'hCCCC_CCCC_CCCC_CCCC, 64'h8888_8888_8888_8888, 1'b1, 1'b1, 0);
    // aborts, then a normal run
    add_entry("abort_1", 64'd12345, 64'd678, 1'b0, 1'b0, 1);
    add_entry("abort_3", 64'hDEAD_BEEF_0000_0001, 64'd3, 1'b1, 1'b0, 3);
    add_entry("abort_5", '1, '1, 1'b0, 1'b0, 5);
    add_entry("after_abort", 64'hFEDC_BA98_7654_3210, 64'h0123_4567_89AB_CDEF, 1'b1, 1'b1, 0);
    for (int i = 0; i < 20; i++) begin
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      r = $random(seed);
      add_entry($sformatf("random_%0d", i), a, b, r[0], r[1], 0);
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %s ok", name);
    end else begin
      fail_cnt++;
      $display("test %s failed with %0d errors", name, test_errs);
    end
  endtask

  // called just after a falling edge
  task automatic run_entry(input int idx);
    string name;
    row_t  exp;
    int    lat;
    bit    seen;
    name = name_q[idx];
    exp = exp_q[idx];
    lat = 0;
    seen = 1'b0;
    test_errs = 0;
    mul_valid = 1'b1;
    rs1_data = rs1_q[idx];
    rs2_data = rs2_q[idx];
    rs1_signed = s1_q[idx];
    rs2_signed = s2_q[idx];
    if (abort_q[idx] == 0) begin
      while (!seen && lat < READY_WAIT) begin
        @(negedge clk);
        lat++;
        if (mul_ready) begin
          seen = 1'b1;
        end
      end
      mul_valid = 1'b0;
      if (!seen) begin
        $display("%s: no ready pulse within %0d cycles", name, READY_WAIT);
        test_errs++;
      end else begin
        // first falling edge already follows the acceptance edge
        if (lat - 1 != EXP_LAT) begin
          $display("Mismatch %s latency: expected %0d actual %0d",
                   name, EXP_LAT, lat - 1);
          test_errs++;
        end
        if (mul_out !== exp) begin
          $display("Mismatch %s: expected %h actual %h", name, exp, mul_out);
          test_errs++;
        end
        @(negedge clk);
        if (mul_ready !== 1'b0) begin
          $display("%s: ready stayed high longer than one cycle", name);
          test_errs++;
        end
        @(negedge clk);
        if (mul_out !== exp) begin
          $display("Mismatch %s (held): expected %h actual %h", name, exp, mul_out);
          test_errs++;
        end
      end
    end else begin
      for (int k = 0; k < abort_q[idx] + 1; k++) begin
        @(negedge clk);
        if (mul_ready) begin
          seen = 1'b1;
        end
      end
      mul_valid = 1'b0;
      repeat (10) begin
        @(negedge clk);
        if (mul_ready) begin
          seen = 1'b1;
        end
      end
      if (seen) begin
        $display("%s: ready pulsed although the request was aborted", name);
        test_errs++;
      end
      if (mul_out !== '0) begin
        $display("Mismatch %s: expected %h actual %h", name, row_t'(0), mul_out);
        test_errs++;
      end
      repeat (2) @(negedge clk);
    end
    finish_test(name);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    mul_valid = 1'b0;
    rs1_signed = 1'b0;
    rs2_signed = 1'b0;
    rs1_data = '0;
    rs2_data = '0;
    seed = 32'hccc8;
    cycle_cnt = 0;
    cycle_limit = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    test_errs = 0;
    build_table();
    cycle_limit = name_q.size() * 12 + 50;

    repeat (5) @(negedge clk);
    rst = 1'b0;
    // one cycle in MUL_RST before idle
    repeat (2) @(negedge clk);

    if (mul_ready !== 1'b0) begin
      $display("after_reset: ready is high before any request");
      test_errs++;
    end
    if (mul_out !== '0) begin
      $display("Mismatch after_reset: expected %h actual %h", row_t'(0), mul_out);
      test_errs++;
    end
    finish_test("after_reset");

    for (int i = 0; i < name_q.size(); i++) begin
      run_entry(i);
    end

    $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== wallace_mul.f ====
+incdir+rtl
rtl/mul_pkg.sv
rtl/booth_r4_encoder.sv
rtl/csa42_row.sv
rtl/csa52_row.sv
rtl/wallace_level.sv
rtl/wallace_tree.sv
rtl/mul_ctrl.sv
rtl/wallace_mul.sv
verification/wallace_mul_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the wallace_mul testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/wallace_mul_sim

verilator --binary --timing -Wno-fatal \
  -f wallace_mul.f \
  --top-module wallace_mul_tb \
  -Mdir obj_dir \
  -o wallace_mul_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$BIN" > "$LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
else
  exit 1
fi
